/* build.f */
design/synapse_isa_pkg.sv
design/visor_pkg.sv
design/visor_link_if.sv
design/target_program.sv
design/synapse_core.sv
design/debug_visor.sv
design/supervised_synapse.sv
verification/tb_supervised_synapse.sv

/* design/debug_visor.sv */
// Debug supervisor
`timescale 1ns/1ps

module debug_visor (
    input  logic                       sysclk,
    input  logic                       rst,
    input  logic                       cmd_valid,
    output logic                       cmd_ready,
    input  visor_pkg::visor_cmd_t      cmd_op,
    input  synapse_isa_pkg::word_t     cmd_data,
    output logic                       rsp_valid,
    input  logic                       rsp_ready,
    output synapse_isa_pkg::word_t     rsp_data,
    output synapse_isa_pkg::pc_t       rom_addr,
    input  synapse_isa_pkg::word_t     rom_data,
    visor_link_if.visor                link
);
    import synapse_isa_pkg::*;
    import visor_pkg::*;

    visor_state_t state;
    visor_state_t state_nxt;
    logic         cmd_fire;
    logic         is_read;
    word_t        rd_word;
    word_t        from_visor;

    assign cmd_ready = ~rsp_valid;          // No new command while a response waits.
    assign cmd_fire  = cmd_valid & cmd_ready;

    always_comb begin
        state_nxt = state;
        if (state == ST_STEP) begin
            state_nxt = ST_PAUSE;           // A step lasts one fetch.
        end
        if (cmd_fire) begin
            case (cmd_op)
                CMD_HOLD:  state_nxt = ST_HOLD;
                CMD_RUN:   state_nxt = ST_RUN;
                CMD_PAUSE: state_nxt = ST_PAUSE;
                CMD_STEP: begin
                    if (state == ST_PAUSE) begin
                        state_nxt = ST_STEP;
                    end
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge sysclk) begin
        if (rst) begin
            state <= ST_HOLD;
        end else begin
            state <= state_nxt;
        end
    end

    // Read commands and the word they return.
    always_comb begin
        is_read = 1'b1;
        rd_word = '0;
        case (cmd_op)
            CMD_PEEK:     rd_word = rom_data;       // Peek at the pending fetch.
            CMD_READ_PC:  rd_word = link.debug_pc;
            CMD_READ_REG: rd_word = link.to_visor;
            default:      is_read = 1'b0;
        endcase
    end

    always_ff @(posedge sysclk) begin
        if (rst) begin
            rsp_valid  <= 1'b0;
            from_visor <= '0;
        end else begin
            if (cmd_fire && is_read) begin
                rsp_valid <= 1'b1;
            end else if (rsp_ready) begin
                rsp_valid <= 1'b0;
            end
            if (cmd_fire && cmd_op == CMD_WRITE) begin
                from_visor <= cmd_data;
            end
        end
    end

    always_ff @(posedge sysclk) begin
        if (cmd_fire && is_read) begin
            rsp_data <= rd_word;            // Held until the host takes it.
        end
    end

    assign rom_addr        = link.code_addr;
    assign link.code_ready = (state == ST_RUN) || (state == ST_STEP);
    assign link.tg_reset   = (state == ST_HOLD);
    assign link.code_in    = link.code_ready ? rom_data : FILL_WORD;
    assign link.from_visor = from_visor;

endmodule

/* design/supervised_synapse.sv */
// Supervised Synapse top level
`timescale 1ns/1ps

module supervised_synapse #(
    parameter int NUM_REGS        = 16,
    parameter int NUM_DATA_INPUTS = 16,
    parameter int DEBUG_REG_NUM   = NUM_REGS - 1
) (
    input  logic                                                    sysclk,
    input  logic                                                    rst,
    // Host command and response channels.
    input  logic                                                    cmd_valid,
    output logic                                                    cmd_ready,
    input  visor_pkg::visor_cmd_t                                   cmd_op,
    input  synapse_isa_pkg::word_t                                  cmd_data,
    output logic                                                    rsp_valid,
    input  logic                                                    rsp_ready,
    output synapse_isa_pkg::word_t                                  rsp_data,
    // Target side.
    output logic [NUM_REGS*synapse_isa_pkg::WORD_W-1:0]             r_flat,
    output logic [NUM_REGS-1:0]                                     r_load,
    input  logic [(NUM_DATA_INPUTS-1)*synapse_isa_pkg::WORD_W-1:0] data_in_flat
);
    import synapse_isa_pkg::*;

    pc_t   rom_addr;
    word_t rom_data;

    visor_link_if link ();

    target_program rom (
        .addr (rom_addr),
        .data (rom_data)
    );

    debug_visor visr (
        .sysclk    (sysclk),
        .rst       (rst),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .cmd_op    (cmd_op),
        .cmd_data  (cmd_data),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp_data  (rsp_data),
        .rom_addr  (rom_addr),
        .rom_data  (rom_data),
        .link      (link.visor)
    );

    synapse_core #(
        .NUM_REGS        (NUM_REGS),
        .NUM_DATA_INPUTS (NUM_DATA_INPUTS),
        .DEBUG_REG_NUM   (DEBUG_REG_NUM)
    ) target (
        .sysclk       (sysclk),
        .link         (link.core),
        .data_in_flat (data_in_flat),
        .r_flat       (r_flat),
        .r_load       (r_load)
    );

endmodule

/* design/synapse_core.sv */
// Synapse single-cycle core
`timescale 1ns/1ps

module synapse_core #(
    parameter int NUM_REGS        = 16,
    parameter int NUM_DATA_INPUTS = 16,
    parameter int DEBUG_REG_NUM   = NUM_REGS - 1
) (
    input  logic                                                    sysclk,
    visor_link_if.core                                              link,
    input  logic [(NUM_DATA_INPUTS-1)*synapse_isa_pkg::WORD_W-1:0] data_in_flat,
    output logic [NUM_REGS*synapse_isa_pkg::WORD_W-1:0]             r_flat,
    output logic [NUM_REGS-1:0]                                     r_load
);
    import synapse_isa_pkg::*;

    word_t    regs [NUM_REGS];          // Register file.
    word_t    din [NUM_DATA_INPUTS];    // Data inputs with the supervisor word last.
    pc_t      pc;

    opcode_t  op;
    reg_idx_t rd;
    reg_idx_t rs;
    reg_idx_t rt;
    word_t    imm8;
    pc_t      imm12;

    logic               wr_en;
    word_t              wr_data;
    pc_t                pc_nxt;
    logic [NUM_REGS-1:0] load_vec;

    // Instruction fields.
    always_comb begin
        op    = opcode_t'(link.code_in[15:12]);
        rd    = link.code_in[11:8];
        rs    = link.code_in[7:4];
        rt    = link.code_in[3:0];
        imm8  = {8'h00, link.code_in[7:0]};
        imm12 = {4'h0, link.code_in[11:0]};
    end

    always_comb begin
        for (int i = 0; i < NUM_DATA_INPUTS - 1; i++) begin
            din[i] = data_in_flat[i*WORD_W +: WORD_W];
        end
        din[NUM_DATA_INPUTS-1] = link.from_visor;
    end

    // Execute stage.
    always_comb begin
        wr_en   = 1'b0;
        wr_data = '0;
        pc_nxt  = pc + 16'd1;
        case (op)
            OP_LDI: begin
                wr_en   = 1'b1;
                wr_data = imm8;
            end
            OP_ADD: begin
                wr_en   = 1'b1;
                wr_data = regs[rs] + regs[rt];
            end
            OP_SUB: begin
                wr_en   = 1'b1;
                wr_data = regs[rs] - regs[rt];
            end
            OP_AND: begin
                wr_en   = 1'b1;
                wr_data = regs[rs] & regs[rt];
            end
            OP_OR: begin
                wr_en   = 1'b1;
                wr_data = regs[rs] | regs[rt];
            end
            OP_XOR: begin
                wr_en   = 1'b1;
                wr_data = regs[rs] ^ regs[rt];
            end
            OP_IN: begin
                wr_en   = 1'b1;
                wr_data = din[rs];
            end
            OP_MOV: begin
                wr_en   = 1'b1;
                wr_data = regs[rs];
            end
            OP_JMP: pc_nxt = imm12;
            OP_JNZ: begin
                if (regs[rd] != '0) begin
                    pc_nxt = imm8;          // Taken branch.
                end
            end
            default: ;                      // NOP and unused codes.
        endcase
    end

    always_comb begin
        load_vec = '0;
        if (wr_en) begin
            load_vec[rd] = 1'b1;
        end
    end

    always_ff @(posedge sysclk) begin
        if (link.tg_reset) begin
            pc     <= '0;
            r_load <= '0;
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (link.code_ready) begin
            pc     <= pc_nxt;
            r_load <= load_vec;             // One-hot pulse on the written register.
            if (wr_en) begin
                regs[rd] <= wr_data;
            end
        end else begin
            r_load <= '0;
        end
    end

    always_comb begin
        for (int i = 0; i < NUM_REGS; i++) begin
            r_flat[i*WORD_W +: WORD_W] = regs[i];
        end
    end

    assign link.code_addr = pc;
    assign link.debug_pc  = pc;
    assign link.to_visor  = regs[DEBUG_REG_NUM];

endmodule

/* design/synapse_isa_pkg.sv */
// Synapse instruction set definitions

package synapse_isa_pkg;

    localparam int WORD_W = 16;     // Data and instruction word width.
    localparam int IDX_W  = 4;      // Register and data input index width.
    localparam int PC_W   = 16;     // Code address width.

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [IDX_W-1:0]  reg_idx_t;
    typedef logic [PC_W-1:0]   pc_t;

    // Field positions are op 15..12, rd 11..8, rs 7..4, rt 3..0, imm8 7..0, imm12 11..0.
    typedef enum logic [3:0] {
        OP_LDI = 4'h0,  // rd = imm8.
        OP_ADD = 4'h1,  // rd = rs + rt.
        OP_SUB = 4'h2,  // rd = rs - rt.
        OP_AND = 4'h3,  // rd = rs & rt.
        OP_OR  = 4'h4,  // rd = rs | rt.
        OP_XOR = 4'h5,  // rd = rs ^ rt.
        OP_IN  = 4'h6,  // rd = data input rs.
        OP_MOV = 4'h7,  // rd = rs.
        OP_JMP = 4'h8,  // pc = imm12.
        OP_JNZ = 4'h9,  // pc = imm8 when rd is non-zero.
        OP_NOP = 4'hf
    } opcode_t;

    // Word fed to the core while a fetch is stalled. It decodes as NOP.
    localparam word_t FILL_WORD = 16'hffff;

endpackage

/* design/target_program.sv */
// Target code ROM
`timescale 1ns/1ps

module target_program (
    input  synapse_isa_pkg::pc_t   addr,
    output synapse_isa_pkg::word_t data
);
    import synapse_isa_pkg::*;

    always_comb begin
        case (addr)
            16'd0:   data = 16'h0105;   // LDI r1, 0x05.
            16'd1:   data = 16'h023c;   // LDI r2, 0x3c.
            16'd2:   data = 16'h6300;   // IN  r3, in0.
            16'd3:   data = 16'h6410;   // IN  r4, in1.
            16'd4:   data = 16'h65f0;   // IN  r5, in15.
            16'd5:   data = 16'h1634;   // ADD r6, r3, r4.
            16'd6:   data = 16'h2762;   // SUB r7, r6, r2.
            16'd7:   data = 16'h3835;   // AND r8, r3, r5.
            16'd8:   data = 16'h4942;   // OR  r9, r4, r2.
            16'd9:   data = 16'h5a89;   // XOR r10, r8, r9.
            16'd10:  data = 16'h7fa0;   // MOV r15, r10.
            16'd11:  data = 16'h1ff7;   // ADD r15, r15, r7.
            16'd12:  data = 16'h0b01;   // LDI r11, 1.
            16'd13:  data = 16'h0c03;   // LDI r12, 3.
            // Countdown loop on r12, folding the count into r15.
            16'd14:  data = 16'h2ccb;   // SUB r12, r12, r11.
            16'd15:  data = 16'h5ffc;   // XOR r15, r15, r12.
            16'd16:  data = 16'h9c0e;   // JNZ r12, 14.
            16'd17:  data = 16'h7df0;   // MOV r13, r15.
            16'd18:  data = 16'h6ef0;   // IN  r14, in15.
            16'd19:  data = 16'h8000;   // JMP 0.
            default: data = FILL_WORD;  // Past the table.
        endcase
    end

endmodule

/* design/visor_link_if.sv */
// Supervisor to core link
`timescale 1ns/1ps

interface visor_link_if;
    import synapse_isa_pkg::*;

    pc_t   code_addr;   // Fetch address from the core.
    pc_t   debug_pc;    // Current pc of the core.
    word_t to_visor;    // Mirror of the debug register.
    word_t code_in;     // Fetched word or filler when stalled.
    logic  code_ready;  // Fetch accepted this cycle.
    logic  tg_reset;    // Active high target reset.
    word_t from_visor;  // Supervisor word on data input 15.

    modport visor (
        input  code_addr, debug_pc, to_visor,
        output code_in, code_ready, tg_reset, from_visor
    );

    modport core (
        output code_addr, debug_pc, to_visor,
        input  code_in, code_ready, tg_reset, from_visor
    );

endinterface

/* design/visor_pkg.sv */
// Debug supervisor definitions

package visor_pkg;

    // Host command codes.
    typedef enum logic [2:0] {
        CMD_HOLD     = 3'd0,    // Keep the target in reset.
        CMD_RUN      = 3'd1,
        CMD_PAUSE    = 3'd2,
        CMD_STEP     = 3'd3,    // One instruction from pause only.
        CMD_PEEK     = 3'd4,    // Word at the current fetch address.
        CMD_READ_PC  = 3'd5,
        CMD_READ_REG = 3'd6,    // Debug register of the target.
        CMD_WRITE    = 3'd7     // Value for data input 15.
    } visor_cmd_t;

    typedef enum logic [1:0] {
        ST_HOLD  = 2'd0,
        ST_RUN   = 2'd1,
        ST_PAUSE = 2'd2,
        ST_STEP  = 2'd3
    } visor_state_t;

endpackage

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_supervised_synapse -f build.f -o tb_sim \
    > build.log 2>&1 \
    && ./obj_dir/tb_sim > sim.log 2>&1 \
    || { cat build.log; echo "Simulation build or run failed"; }

cat sim.log 2>/dev/null
grep -qx "Test OK" sim.log 2>/dev/null && exit 0 || exit 1

/* verification/tb_supervised_synapse.sv */
// Supervised Synapse testbench
`timescale 1ns/1ps

module tb_supervised_synapse;
    import synapse_isa_pkg::*;
    import visor_pkg::*;

    localparam int NUM_REGS        = 16;
    localparam int NUM_DATA_INPUTS = 16;
    localparam int DEBUG_REG_NUM   = NUM_REGS - 1;
    localparam int TIMEOUT         = 50;    // Cycles allowed per wait.
    localparam int PROG_LEN        = 20;    // Words in the target program.

    typedef logic [NUM_REGS*WORD_W-1:0]            reg_flat_t;
    typedef logic [NUM_REGS-1:0]                   load_vec_t;
    typedef logic [(NUM_DATA_INPUTS-1)*WORD_W-1:0] din_flat_t;

    logic       sysclk = 1'b0;
    logic       rst;
    logic       cmd_valid;
    logic       cmd_ready;
    visor_cmd_t cmd_op;
    word_t      cmd_data;
    logic       rsp_valid;
    logic       rsp_ready;
    word_t      rsp_data;
    reg_flat_t  r_flat;
    load_vec_t  r_load;
    din_flat_t  data_in_flat;

    int          errors;
    logic [31:0] rng_state;
    word_t       model_regs [NUM_REGS];
    word_t       model_din [NUM_DATA_INPUTS];  // Last entry mirrors the supervisor word.
    pc_t         model_pc;

    supervised_synapse #(
        .NUM_REGS        (NUM_REGS),
        .NUM_DATA_INPUTS (NUM_DATA_INPUTS),
        .DEBUG_REG_NUM   (DEBUG_REG_NUM)
    ) dut (
        .sysclk       (sysclk),
        .rst          (rst),
        .cmd_valid    (cmd_valid),
        .cmd_ready    (cmd_ready),
        .cmd_op       (cmd_op),
        .cmd_data     (cmd_data),
        .rsp_valid    (rsp_valid),
        .rsp_ready    (rsp_ready),
        .rsp_data     (rsp_data),
        .r_flat       (r_flat),
        .r_load       (r_load),
        .data_in_flat (data_in_flat)
    );

    always #4 sysclk = ~sysclk;             // 8 ns period.

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic word_t rand_word();
        rng_state = xorshift32(rng_state);
        return rng_state[15:0];
    endfunction

    // Expected effect of one instruction.
    // A wr_idx of -1 means no register is written.
    function automatic pc_t ref_exec(input word_t instr, input pc_t pc,
            input word_t regs_in [NUM_REGS], input word_t din [NUM_DATA_INPUTS],
            output word_t regs_out [NUM_REGS], output int wr_idx);
        reg_idx_t rd;
        reg_idx_t rs;
        reg_idx_t rt;
        word_t    a;
        word_t    b;
        pc_t      next_pc;
        rd       = instr[11:8];
        rs       = instr[7:4];
        rt       = instr[3:0];
        a        = regs_in[rs];
        b        = regs_in[rt];
        regs_out = regs_in;
        wr_idx   = int'(rd);
        next_pc  = pc + 16'd1;
        case (instr[15:12])
            OP_LDI: regs_out[rd] = {8'h00, instr[7:0]};
            OP_ADD: regs_out[rd] = a + b;
            OP_SUB: regs_out[rd] = a - b;
            OP_AND: regs_out[rd] = a & b;
            OP_OR:  regs_out[rd] = a | b;
            OP_XOR: regs_out[rd] = a ^ b;
            OP_IN:  regs_out[rd] = din[rs];
            OP_MOV: regs_out[rd] = a;
            OP_JMP: begin
                wr_idx  = -1;
                next_pc = {4'h0, instr[11:0]};
            end
            OP_JNZ: begin
                wr_idx = -1;
                if (regs_in[rd] != 16'h0000) begin
                    next_pc = {8'h00, instr[7:0]};
                end
            end
            default: wr_idx = -1;           // NOP and unused codes.
        endcase
        return next_pc;
    endfunction

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (exp !== act) begin
            errors++;
            $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_regs(input string name, input reg_flat_t exp, input reg_flat_t act);
        if (exp !== act) begin
            errors++;
            $display("CHECK FAILED %s regs: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_load(input string name, input load_vec_t exp, input load_vec_t act);
        if (exp !== act) begin
            errors++;
            $display("CHECK FAILED %s r_load: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            errors++;
            $display("CHECK FAILED %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    // Register file and load pulse against the model.
    task automatic compare_target(input string name, input int wr_idx);
        reg_flat_t exp_flat;
        load_vec_t exp_load;
        exp_load = '0;
        for (int i = 0; i < NUM_REGS; i++) begin
            exp_flat[i*WORD_W +: WORD_W] = model_regs[i];
        end
        if (wr_idx >= 0) begin
            exp_load[wr_idx] = 1'b1;
        end
        check_regs(name, exp_flat, r_flat);
        check_load(name, exp_load, r_load);
    endtask

    task automatic wait_cycles(input int n);
        for (int i = 0; i < n; i++) begin
            @(negedge sysclk);
        end
    endtask

    task automatic send_cmd(input visor_cmd_t op, input word_t data);
        int   waited;
        logic taken;
        waited = 0;
        taken  = 1'b0;
        @(posedge sysclk);
        cmd_valid <= 1'b1;
        cmd_op    <= op;
        cmd_data  <= data;
        while (!taken && waited < TIMEOUT) begin
            @(negedge sysclk);
            taken = cmd_ready;              // Transfer on the next rising edge.
            @(posedge sysclk);
            waited++;
        end
        cmd_valid <= 1'b0;
        if (!taken) begin
            errors++;
            $display("Timeout: supervisor did not accept command %s", op.name());
        end
    endtask

    task automatic wait_rsp(output logic seen);
        int waited;
        waited = 0;
        seen   = 1'b0;
        while (!seen && waited < TIMEOUT) begin
            @(negedge sysclk);
            seen = rsp_valid;
            waited++;
        end
        if (!seen) begin
            errors++;
            $display("Timeout: no response came from the supervisor");
        end
    endtask

    task automatic get_rsp(output word_t data);
        logic seen;
        wait_rsp(seen);
        data = rsp_data;
        if (seen) begin
            @(posedge sysclk);
            rsp_ready <= 1'b1;
            @(posedge sysclk);              // Response transfers here.
            rsp_ready <= 1'b0;
        end
    endtask

    task automatic read_word(input visor_cmd_t op, output word_t data);
        send_cmd(op, 16'h0000);
        get_rsp(data);
    endtask

    initial begin
        word_t     instr;
        word_t     rsp;
        word_t     held;
        word_t     rnd;
        word_t     next_regs [NUM_REGS];
        int        wr_idx;
        logic      seen;
        din_flat_t din_v;
        errors    = 0;
        rng_state = 32'hc2475fab;
        rst       = 1'b1;
        cmd_valid = 1'b0;
        cmd_op    = CMD_HOLD;
        cmd_data  = '0;
        rsp_ready = 1'b0;
        data_in_flat = '0;
        model_pc  = '0;
        for (int i = 0; i < NUM_REGS; i++) begin
            model_regs[i] = '0;
        end
        for (int i = 0; i < NUM_DATA_INPUTS - 1; i++) begin
            model_din[i] = rand_word();
            din_v[i*WORD_W +: WORD_W] = model_din[i];
        end
        model_din[NUM_DATA_INPUTS-1] = '0;
        @(posedge sysclk);
        data_in_flat <= din_v;
        repeat (2) @(posedge sysclk);
        rst <= 1'b0;

        // The target sits in hold after reset.
        wait_cycles(2);
        check_flag("reset cmd_ready", 1'b1, cmd_ready);
        check_flag("reset rsp_valid", 1'b0, rsp_valid);
        compare_target("reset", -1);
        read_word(CMD_READ_PC, rsp);
        check_word("reset pc", 16'h0000, rsp);

        send_cmd(CMD_PAUSE, 16'h0000);
        for (int step = 0; step < 40; step++) begin
            read_word(CMD_PEEK, instr);
            if (instr[15:12] == OP_IN && instr[7:4] == 4'hf) begin
                model_din[NUM_DATA_INPUTS-1] = rand_word();
                send_cmd(CMD_WRITE, model_din[NUM_DATA_INPUTS-1]);
            end
            send_cmd(CMD_STEP, 16'h0000);
            model_pc   = ref_exec(instr, model_pc, model_regs, model_din, next_regs, wr_idx);
            model_regs = next_regs;
            wait_cycles(2);                 // Executes on the edge after acceptance.
            compare_target($sformatf("step %0d", step), wr_idx);
            read_word(CMD_READ_PC, rsp);
            check_word($sformatf("step %0d pc", step), model_pc, rsp);
            read_word(CMD_READ_REG, rsp);
            check_word($sformatf("step %0d r15", step), model_regs[DEBUG_REG_NUM], rsp);
        end

        // Host holds the response back.
        send_cmd(CMD_READ_PC, 16'h0000);
        wait_rsp(seen);
        held = rsp_data;
        for (int i = 0; i < 6; i++) begin
            @(negedge sysclk);
            check_flag("backpressure rsp_valid", 1'b1, rsp_valid);
            check_flag("backpressure cmd_ready", 1'b0, cmd_ready);
            check_word("backpressure rsp_data", held, rsp_data);
        end
        get_rsp(rsp);
        check_word("backpressure pc", model_pc, rsp);
        read_word(CMD_READ_REG, rsp);
        check_word("read after backpressure", model_regs[DEBUG_REG_NUM], rsp);

        rnd = rand_word();
        send_cmd(CMD_RUN, 16'h0000);
        wait_cycles(int'(rnd[5:0]) + 8);
        send_cmd(CMD_PAUSE, 16'h0000);
        read_word(CMD_READ_PC, rsp);
        if (int'(rsp) >= PROG_LEN) begin
            errors++;
            $display("Free run left the pc at %h, outside the program", rsp);
        end

        send_cmd(CMD_HOLD, 16'h0000);
        wait_cycles(2);
        model_pc = '0;
        for (int i = 0; i < NUM_REGS; i++) begin
            model_regs[i] = '0;
        end
        compare_target("hold", -1);
        read_word(CMD_READ_PC, rsp);
        check_word("hold pc", model_pc, rsp);
        send_cmd(CMD_STEP, 16'h0000);       // Ignored outside pause.
        wait_cycles(3);
        compare_target("step in hold", -1);
        read_word(CMD_READ_PC, rsp);
        check_word("step in hold pc", model_pc, rsp);

        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule
